// ==== Bender.yml ====
package:
  name: snes_rom_ctrl

sources:
  - verilog/snes_rom_pkg.sv
  - verilog/snes_bus_sync.sv
  - verilog/snes_addr_decode.sv
  - verilog/mcu_rom_arbiter.sv
  - verilog/rom_bus_mux.sv
  - verilog/snes_rom_ctrl.sv
  - target: simulation
    files:
      - sim/rom_ctrl_checker.sv
      - sim/tb_snes_rom_ctrl.sv

// ==== sim/rom_ctrl_checker.sv ====
`timescale 1ns/1ns

module rom_ctrl_checker (
  input  logic                     CLK2,
  input  logic                     rst,
  input  snes_rom_pkg::snes_addr_t snes_addr_in,
  input  logic                     snes_read_in,
  input  logic                     snes_romsel_in,
  input  logic                     snes_cpu_clk_in,
  input  logic [7:0]               snes_data,
  input  logic                     snes_databus_oe,
  input  logic                     snes_databus_dir,
  input  logic [15:0]              rom_data,
  input  logic [22:0]              rom_addr,
  input  logic                     rom_we,
  input  logic                     rom_bhe,
  input  logic                     rom_ble,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  snes_rom_pkg::rom_addr_t  mcu_addr,
  input  logic [7:0]               mcu_dout,
  input  logic [7:0]               mcu_din,
  input  logic                     mcu_rdy,
  input  snes_rom_pkg::mapper_t    mapper,
  input  snes_rom_pkg::rom_addr_t  rom_mask,
  output int                       err_cnt,
  output int                       mcu_checks,
  output int                       con_checks
);

  import snes_rom_pkg::*;

  logic [7:0] shadow [0:65535];   // expected ROM bytes
  rom_addr_t  req_addr;
  logic [7:0] req_data;
  logic       req_wr;
  logic       busy;
  logic       wr_seen;
  logic       expect_fall;
  logic       rdy_prev;
  logic       reset_checked;
  logic       prev_clk;
  logic       prev_read;
  logic       prev_romsel;
  logic       prev_oe;
  logic       prev_dir;
  snes_addr_t prev_addr;
  logic [7:0] prev_data;
  rom_addr_t  exp_addr;
  logic [7:0] got_lane;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic rom_addr_t ref_map(snes_addr_t a, mapper_t m, rom_addr_t mask);
    if (m == map_lorom) begin
      return (((a >> 1) & 24'h3f8000) | (a & 24'h007fff)) & mask;   // A15 squeezed out
    end
    return a & mask;
  endfunction

  function automatic logic ref_is_rom(snes_addr_t a, mapper_t m);
    return (m == map_lorom) ? a[15] : (a[22] | a[15]);
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return a[7:0] ^ {a[10:8], a[15:11]} ^ 8'h3c;
  endfunction

  task automatic report_value(input string name, input logic [23:0] got,
                              input logic [23:0] exp);
    $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
    err_cnt++;
  endtask

  task automatic report_event(input string msg);
    $display("%s at %0t", msg, $time);
    err_cnt++;
  endtask

  initial begin
    err_cnt    = 0;
    mcu_checks = 0;
    con_checks = 0;
    for (int i = 0; i < 65536; i++) begin
      shadow[i] = fill_byte(i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // comparisons, sampled mid-period
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge CLK2) begin
    if (rst) begin
      busy          = 1'b0;
      expect_fall   = 1'b0;
      rdy_prev      = 1'b1;
      reset_checked = 1'b0;
      prev_clk      = 1'b0;
      prev_read     = 1'b1;
      prev_romsel   = 1'b1;
    end else begin
      if (!reset_checked) begin
        if (mcu_rdy !== 1'b1) report_value("mcu_rdy", mcu_rdy, 1);
        if (rom_we !== 1'b1) report_value("rom_we", rom_we, 1);
        if (snes_databus_oe !== 1'b1) report_value("snes_databus_oe", snes_databus_oe, 1);
        reset_checked = 1'b1;
      end
      if (expect_fall && mcu_rdy !== 1'b0) begin
        report_event("mcu_rdy did not fall after a request");
      end
      expect_fall = 1'b0;
      if (mcu_rrq || mcu_wrq) begin
        req_addr    = mcu_addr;
        req_data    = mcu_dout;
        req_wr      = mcu_wrq;
        busy        = 1'b1;
        wr_seen     = 1'b0;
        expect_fall = 1'b1;
        if (mcu_wrq) shadow[mcu_addr[15:0]] = mcu_dout;
      end
      if (rom_we === 1'b0) begin
        if (!busy || !req_wr) begin
          report_event("rom_we went low with no write pending");
        end else begin
          wr_seen  = 1'b1;
          got_lane = req_addr[0] ? rom_data[7:0] : rom_data[15:8];
          if (rom_addr !== req_addr[23:1]) report_value("rom_addr", rom_addr, req_addr[23:1]);
          if (rom_bhe !== req_addr[0]) report_value("rom_bhe", rom_bhe, req_addr[0]);
          if (rom_ble !== ~req_addr[0]) report_value("rom_ble", rom_ble, ~req_addr[0]);
          if (got_lane !== req_data) report_value("rom_data lane", got_lane, req_data);
        end
      end
      // rising mcu_rdy ends the access
      if (busy && mcu_rdy === 1'b1 && rdy_prev === 1'b0) begin
        busy = 1'b0;
        mcu_checks++;
        if (req_wr && !wr_seen) begin
          report_event("mcu write finished without a ROM write strobe");
        end else if (!req_wr && mcu_din !== shadow[req_addr[15:0]]) begin
          report_value("mcu_din", mcu_din, shadow[req_addr[15:0]]);
        end
      end
      rdy_prev = mcu_rdy;
      // falling cpu clock closes a console cycle
      if (prev_clk && !snes_cpu_clk_in && !prev_read && !prev_romsel) begin
        con_checks++;
        if (ref_is_rom(prev_addr, mapper)) begin
          exp_addr = ref_map(prev_addr, mapper, rom_mask);
          if (prev_data !== shadow[exp_addr[15:0]]) begin
            report_value("snes_data", prev_data, shadow[exp_addr[15:0]]);
          end
          if (prev_oe !== 1'b0) report_value("snes_databus_oe", prev_oe, 0);
          if (prev_dir !== 1'b1) report_value("snes_databus_dir", prev_dir, 1);
        end else if (prev_oe !== 1'b1) begin
          report_value("snes_databus_oe", prev_oe, 1);   // no ROM, bus stays off
        end
      end
      prev_clk    = snes_cpu_clk_in;
      prev_read   = snes_read_in;
      prev_romsel = snes_romsel_in;
      prev_addr   = snes_addr_in;
      prev_data   = snes_data;
      prev_oe     = snes_databus_oe;
      prev_dir    = snes_databus_dir;
    end
  end

endmodule

// ==== sim/tb_snes_rom_ctrl.sv ====
`timescale 1ns/1ns

module tb_snes_rom_ctrl;

  import snes_rom_pkg::*;

  localparam int period       = 20;
  localparam int dead_cyc     = 200;
  localparam int cycle_len    = 8;
  localparam int half_cyc     = 12;   // cpu clock half period in CLK2 cycles
  localparam int n_writes     = 16;
  localparam int n_con        = 12;
  localparam int n_busy       = 6;
  localparam int n_mcu_acc    = 2 * n_writes + 2 * n_busy;
  localparam int n_con_reads  = 4 * n_con;
  localparam int n_access     = 2 * n_writes + 4 * n_con + 2 * n_busy;
  localparam int worst_cyc    = 4 * half_cyc + cycle_len + 3;
  localparam int access_limit = worst_cyc + 2 * dead_cyc;
  localparam int wd_cycles    = n_access * worst_cyc + 4 * dead_cyc + 500;

  logic        CLK2;
  logic        rst;
  snes_addr_t  snes_addr_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in;
  wire  [7:0]  snes_data;
  logic        snes_databus_oe;
  logic        snes_databus_dir;
  wire  [15:0] rom_data;
  logic [22:0] rom_addr;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;
  logic        mcu_rrq;
  logic        mcu_wrq;
  rom_addr_t   mcu_addr;
  logic [7:0]  mcu_dout;
  logic [7:0]  mcu_din;
  logic        mcu_rdy;
  mapper_t     mapper;
  rom_addr_t   rom_mask;
  int          err_cnt;
  int          mcu_checks;
  int          con_checks;
  int          tmo_cnt;
  integer      seed;
  rom_addr_t   wr_addr   [0:n_writes-1];
  rom_addr_t   busy_addr [0:n_busy-1];
  logic [7:0]  busy_data [0:n_busy-1];
  logic [7:0]  rom_mem   [0:65535];
  logic [15:0] rom_word;

  initial CLK2 = 1'b0;
  always #(period / 2) CLK2 = ~CLK2;

  snes_rom_ctrl #(
    .dead_timeout  (18'(dead_cyc)),
    .rom_cycle_len (4'(cycle_len))
  ) dut (
    .CLK2             (CLK2),
    .rst              (rst),
    .snes_addr_in     (snes_addr_in),
    .snes_read_in     (snes_read_in),
    .snes_write_in    (snes_write_in),
    .snes_romsel_in   (snes_romsel_in),
    .snes_cpu_clk_in  (snes_cpu_clk_in),
    .snes_data        (snes_data),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir),
    .rom_data         (rom_data),
    .rom_addr         (rom_addr),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .mcu_rrq          (mcu_rrq),
    .mcu_wrq          (mcu_wrq),
    .mcu_addr         (mcu_addr),
    .mcu_dout         (mcu_dout),
    .mcu_din          (mcu_din),
    .mcu_rdy          (mcu_rdy),
    .mapper           (mapper),
    .rom_mask         (rom_mask)
  );

  rom_ctrl_checker chk (.*);

  ////////////////////////////////////////////////////////////////////////////
  // 64K ROM model with the even byte on the high lane
  ////////////////////////////////////////////////////////////////////////////

  assign rom_word = {rom_mem[{rom_addr[14:0], 1'b0}], rom_mem[{rom_addr[14:0], 1'b1}]};
  assign rom_data = (rom_we === 1'b1) ? rom_word : 16'bz;

  always @(posedge CLK2) begin
    if (rom_we === 1'b0) begin
      if (rom_bhe) rom_mem[{rom_addr[14:0], 1'b1}] <= rom_data[7:0];
      else         rom_mem[{rom_addr[14:0], 1'b0}] <= rom_data[15:8];
    end
  end

  function automatic logic [7:0] fill_byte(input int a);
    return a[7:0] ^ {a[10:8], a[15:11]} ^ 8'h3c;
  endfunction

  task automatic mcu_request(input logic wr, input rom_addr_t a, input logic [7:0] d);
    int n;
    n = 0;
    @(posedge CLK2);
    mcu_addr <= a;
    mcu_dout <= d;
    if (wr) mcu_wrq <= 1'b1;
    else    mcu_rrq <= 1'b1;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    while (mcu_rdy !== 1'b1 && n < access_limit) begin
      @(negedge CLK2);
      n++;
    end
    if (mcu_rdy !== 1'b1) begin
      $display("mcu access to %h never completed", a);
      tmo_cnt++;
    end
  endtask

  // one console read of a random address in a low and a high phase
  task automatic console_cycle();
    snes_addr_t a;
    a     = $random(seed);
    a[14] = 1'b0;   // keeps clear of 0xC000-0xFFFF
    if (($random(seed) & 3) == 0) begin
      a[22] = 1'b0;
      a[15] = 1'b0;
    end else if (mapper == map_hirom) begin
      a[22] = 1'b1;
    end else begin
      a[15] = 1'b1;
    end
    @(posedge CLK2);
    snes_addr_in    <= a;
    snes_read_in    <= 1'b0;
    snes_romsel_in  <= 1'b0;
    snes_cpu_clk_in <= 1'b0;
    repeat (half_cyc) @(posedge CLK2);
    snes_cpu_clk_in <= 1'b1;
    repeat (half_cyc - 1) @(posedge CLK2);
  endtask

  task automatic console_stop();
    @(posedge CLK2);
    snes_read_in    <= 1'b1;
    snes_romsel_in  <= 1'b1;
    snes_cpu_clk_in <= 1'b0;
  endtask

  initial begin
    seed            = 32'h88b5;
    tmo_cnt         = 0;
    rst             = 1'b1;
    snes_addr_in    = '0;
    snes_read_in    = 1'b1;
    snes_write_in   = 1'b1;
    snes_romsel_in  = 1'b1;
    snes_cpu_clk_in = 1'b0;
    mcu_rrq         = 1'b0;
    mcu_wrq         = 1'b0;
    mcu_addr        = '0;
    mcu_dout        = 8'h00;
    mapper          = map_hirom;
    rom_mask        = 24'h00ffff;
    for (int i = 0; i < 65536; i++) begin
      rom_mem[i] = fill_byte(i);
    end
    repeat (5) @(posedge CLK2);
    rst <= 1'b0;
    repeat (4) @(posedge CLK2);

    // writes then reads back while the console is dead
    for (int i = 0; i < n_writes; i++) begin
      wr_addr[i] = {8'h00, 16'($random(seed))};
      mcu_request(1'b1, wr_addr[i], 8'($random(seed)));
    end
    for (int i = 0; i < n_writes; i++) begin
      mcu_request(1'b0, wr_addr[i], 8'h00);
    end

    // console reads under both mappers
    for (int i = 0; i < n_con; i++) console_cycle();
    console_stop();
    @(posedge CLK2);
    mapper <= map_lorom;
    for (int i = 0; i < n_con; i++) console_cycle();
    console_stop();

    // mcu traffic squeezed into free slots
    for (int i = 0; i < n_busy; i++) begin
      busy_addr[i] = {8'h00, 2'b11, 14'($random(seed))};
      busy_data[i] = 8'($random(seed));
    end
    fork
      begin
        for (int i = 0; i < 2 * n_con; i++) console_cycle();
        console_stop();
      end
      begin
        repeat (3 * half_cyc) @(posedge CLK2);
        for (int i = 0; i < n_busy; i++) begin
          mcu_request(1'b1, busy_addr[i], busy_data[i]);
          mcu_request(1'b0, busy_addr[i], 8'h00);
        end
      end
    join

    repeat (10) @(posedge CLK2);
    if (con_checks != n_con_reads || mcu_checks != n_mcu_acc) begin
      $display("number of checked accesses differs from the number issued");
    end
    $display("errors %0d, timeouts %0d, mcu accesses checked %0d of %0d, %s %0d of %0d",
             err_cnt, tmo_cnt, mcu_checks, n_mcu_acc, "console reads checked",
             con_checks, n_con_reads);
    if (err_cnt == 0 && tmo_cnt == 0 && con_checks == n_con_reads &&
        mcu_checks == n_mcu_acc) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(wd_cycles * period);
    $display("watchdog expired after %0d cycles, run did not finish", wd_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== snes_rom_ctrl.f ====
verilog/snes_rom_pkg.sv
verilog/snes_bus_sync.sv
verilog/snes_addr_decode.sv
verilog/mcu_rom_arbiter.sv
verilog/rom_bus_mux.sv
verilog/snes_rom_ctrl.sv
sim/rom_ctrl_checker.sv
sim/tb_snes_rom_ctrl.sv

// ==== verilog/mcu_rom_arbiter.sv ====
`timescale 1ns/1ns

module mcu_rom_arbiter #(
  parameter logic [3:0] rom_cycle_len = snes_rom_pkg::def_rom_cycle_len
) (
  input  logic                     CLK2,
  input  logic                     rst,
  input  logic                     cycle_start,
  input  logic                     cycle_end,
  input  logic                     rom_hit,
  input  logic                     snes_dead,
  input  logic                     snes_alive,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  snes_rom_pkg::rom_addr_t  mcu_addr,
  output snes_rom_pkg::arb_state_t state,
  output snes_rom_pkg::rom_addr_t  rom_addr_mcu,
  output logic                     mcu_rdy
);

  import snes_rom_pkg::*;

  logic       free_strobe;
  logic       free_slot;
  logic       rd_pend;
  logic       wr_pend;
  logic       access_end;
  logic [3:0] delay_cnt;

  assign free_slot  = cycle_end | free_strobe;
  assign access_end = (state == st_rd_end) || (state == st_wr_end);

  // console cycle without ROM access leaves the bus to us
  always_ff @(posedge CLK2) begin
    if (rst) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // request latch
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) begin
      rom_addr_mcu <= mcu_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // access FSM
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      state     <= st_idle;
      delay_cnt <= '0;
    end else if (snes_dead && snes_alive) begin
      state <= st_idle;   // console woke up, retry in a free slot
    end else begin
      case (state)
        st_idle: begin
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state     <= st_rd_addr;
              delay_cnt <= rom_cycle_len;
            end else if (wr_pend) begin
              state     <= st_wr_addr;
              delay_cnt <= rom_cycle_len;
            end
          end
        end
        st_rd_addr, st_wr_addr: begin
          delay_cnt <= delay_cnt - 4'd1;
          if (delay_cnt == 4'd0) begin
            state <= (state == st_rd_addr) ? st_rd_end : st_wr_end;
          end
        end
        st_rd_end, st_wr_end: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// ==== verilog/rom_bus_mux.sv ====
`timescale 1ns/1ns

module rom_bus_mux (
  input  logic                     CLK2,
  input  logic                     rst,
  input  snes_rom_pkg::arb_state_t state,
  input  snes_rom_pkg::rom_addr_t  rom_addr_mcu,
  input  snes_rom_pkg::rom_addr_t  mapped_addr,
  input  logic                     rom_hit,
  input  logic                     snes_read,
  input  logic [7:0]               mcu_dout,
  inout  wire  [15:0]              rom_data,
  inout  wire  [7:0]               snes_data,
  output logic [22:0]              rom_addr,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble,
  output logic [7:0]               mcu_din,
  output logic                     snes_databus_oe,
  output logic                     snes_databus_dir
);

  import snes_rom_pkg::*;

  rom_addr_t  sel_addr;
  logic       mcu_hit;
  logic       mcu_wr_hit;
  logic       snes_rd_hit;
  logic [7:0] rom_lane;
  logic [7:0] snes_dout;

  assign mcu_hit    = (state != st_idle);
  assign mcu_wr_hit = (state == st_wr_addr) || (state == st_wr_end);

  //////////////////////////////////////////////////////////////////////////////
  // ROM side
  //////////////////////////////////////////////////////////////////////////////

  assign sel_addr = mcu_hit ? rom_addr_mcu : mapped_addr;
  assign rom_addr = sel_addr[23:1];
  assign rom_bhe  = sel_addr[0];    // odd byte on the low lane
  assign rom_ble  = ~sel_addr[0];
  assign rom_lane = sel_addr[0] ? rom_data[7:0] : rom_data[15:8];

  assign rom_data[7:0]  = (mcu_wr_hit && sel_addr[0]) ? mcu_dout : 8'bz;
  assign rom_data[15:8] = (mcu_wr_hit && !sel_addr[0]) ? mcu_dout : 8'bz;
  assign rom_we         = ~(state == st_wr_addr);

  always_ff @(posedge CLK2) begin
    if (rst) begin
      mcu_din <= 8'h00;
    end else if (state == st_rd_addr) begin
      mcu_din <= rom_lane;   // last sample of the wait wins
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // console side
  //////////////////////////////////////////////////////////////////////////////

  // hold console data while the bus is lent out
  always_ff @(posedge CLK2) begin
    if (!mcu_hit) begin
      snes_dout <= rom_lane;
    end
  end

  assign snes_rd_hit      = rom_hit & ~snes_read;
  assign snes_data        = snes_rd_hit ? snes_dout : 8'bz;
  assign snes_databus_oe  = ~snes_rd_hit;
  assign snes_databus_dir = ~snes_read;   // 1 = towards console

endmodule

// ==== verilog/snes_addr_decode.sv ====
`timescale 1ns/1ns

module snes_addr_decode (
  input  logic                     CLK2,
  input  logic                     rst,
  input  snes_rom_pkg::snes_addr_t snes_addr,
  input  logic                     snes_romsel,
  input  snes_rom_pkg::mapper_t    mapper,
  input  snes_rom_pkg::rom_addr_t  rom_mask,
  output snes_rom_pkg::rom_addr_t  mapped_addr,
  output logic                     rom_hit
);

  import snes_rom_pkg::*;

  rom_addr_t addr_next;
  logic      is_rom;

  always_comb begin
    if (mapper == map_lorom) begin
      // 32K banks, A15 only selects the upper half
      addr_next = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;
      is_rom    = snes_addr[15];
    end else begin
      addr_next = snes_addr & rom_mask;
      is_rom    = snes_addr[22] | snes_addr[15];   // 40-7d full, 00-3f upper
    end
  end

  always_ff @(posedge CLK2) begin
    mapped_addr <= addr_next;
  end

  always_ff @(posedge CLK2) begin
    if (rst) begin
      rom_hit <= 1'b0;
    end else begin
      rom_hit <= is_rom & ~snes_romsel;
    end
  end

endmodule

// ==== verilog/snes_bus_sync.sv ====
`timescale 1ns/1ns

module snes_bus_sync #(
  parameter logic [17:0] dead_timeout = snes_rom_pkg::def_dead_timeout
) (
  input  logic                     CLK2,
  input  logic                     rst,
  input  snes_rom_pkg::snes_addr_t snes_addr_in,
  input  logic                     snes_read_in,
  input  logic                     snes_write_in,
  input  logic                     snes_romsel_in,
  input  logic                     snes_cpu_clk_in,
  input  logic [7:0]               snes_data_in,
  output snes_rom_pkg::snes_addr_t snes_addr,
  output logic [7:0]               snes_data,
  output logic                     snes_read,
  output logic                     snes_write,
  output logic                     snes_romsel,
  output logic                     cycle_start,
  output logic                     cycle_end,
  output logic                     snes_dead,
  output logic                     snes_alive
);

  import snes_rom_pkg::*;

  logic [6:0]  read_r;
  logic [6:0]  write_r;
  logic [6:0]  romsel_r;
  logic [6:0]  cpu_clk_r;
  snes_addr_t  addr_r [0:4];
  logic [7:0]  data_r [0:4];
  logic [17:0] dead_cnt;

  //////////////////////////////////////////////////////////////////////////////
  // oversampling
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      read_r    <= '1;   // strobes idle high
      write_r   <= '1;
      romsel_r  <= '1;
      cpu_clk_r <= '0;
    end else begin
      read_r    <= {read_r[5:0], snes_read_in};
      write_r   <= {write_r[5:0], snes_write_in};
      romsel_r  <= {romsel_r[5:0], snes_romsel_in};
      cpu_clk_r <= {cpu_clk_r[5:0], snes_cpu_clk_in};
    end
  end

  // address and data get longer to settle
  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    data_r[0] <= snes_data_in;
    for (int i = 1; i < 5; i++) begin
      addr_r[i] <= addr_r[i-1];
      data_r[i] <= data_r[i-1];
    end
  end

  // two adjacent taps ANDed, drops single-sample glitches
  assign snes_read   = read_r[2] & read_r[1];
  assign snes_write  = write_r[2] & write_r[1];
  assign snes_romsel = romsel_r[2] & romsel_r[1];
  assign snes_addr   = addr_r[4] & addr_r[3];
  assign snes_data   = data_r[4] & data_r[3];

  // edges need five stable samples before the change
  assign cycle_start = (cpu_clk_r[6:1] == 6'b000001);
  assign cycle_end   = (cpu_clk_r[6:1] == 6'b111110);
  assign snes_alive  = cpu_clk_r[1];

  //////////////////////////////////////////////////////////////////////////////
  // dead console detection
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
    end else if (snes_alive) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (!snes_dead) begin
        dead_cnt <= dead_cnt + 18'd1;   // parks once dead
      end
      if (dead_cnt > dead_timeout) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/snes_rom_ctrl.sv ====
`timescale 1ns/1ns

module snes_rom_ctrl #(
  parameter logic [17:0] dead_timeout  = snes_rom_pkg::def_dead_timeout,
  parameter logic [3:0]  rom_cycle_len = snes_rom_pkg::def_rom_cycle_len
) (
  input  logic                     CLK2,
  input  logic                     rst,
  // console
  input  snes_rom_pkg::snes_addr_t snes_addr_in,
  input  logic                     snes_read_in,
  input  logic                     snes_write_in,
  input  logic                     snes_romsel_in,
  input  logic                     snes_cpu_clk_in,
  inout  wire  [7:0]               snes_data,
  output logic                     snes_databus_oe,
  output logic                     snes_databus_dir,
  // ROM
  inout  wire  [15:0]              rom_data,
  output logic [22:0]              rom_addr,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble,
  // microcontroller
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  snes_rom_pkg::rom_addr_t  mcu_addr,
  input  logic [7:0]               mcu_dout,
  output logic [7:0]               mcu_din,
  output logic                     mcu_rdy,
  // configuration
  input  snes_rom_pkg::mapper_t    mapper,
  input  snes_rom_pkg::rom_addr_t  rom_mask
);

  import snes_rom_pkg::*;

  snes_addr_t snes_addr;
  logic       snes_read;
  logic       snes_romsel;
  logic       cycle_start;
  logic       cycle_end;
  logic       snes_dead;
  logic       snes_alive;
  rom_addr_t  mapped_addr;
  rom_addr_t  rom_addr_mcu;
  logic       rom_hit;
  arb_state_t state;

  snes_bus_sync #(
    .dead_timeout (dead_timeout)
  ) u_bus_sync (
    .CLK2            (CLK2),
    .rst             (rst),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_data_in    (snes_data),
    .snes_addr       (snes_addr),
    .snes_data       (),              // console never writes ROM here
    .snes_read       (snes_read),
    .snes_write      (),
    .snes_romsel     (snes_romsel),
    .cycle_start     (cycle_start),
    .cycle_end       (cycle_end),
    .snes_dead       (snes_dead),
    .snes_alive      (snes_alive)
  );

  snes_addr_decode u_addr_decode (
    .CLK2        (CLK2),
    .rst         (rst),
    .snes_addr   (snes_addr),
    .snes_romsel (snes_romsel),
    .mapper      (mapper),
    .rom_mask    (rom_mask),
    .mapped_addr (mapped_addr),
    .rom_hit     (rom_hit)
  );

  mcu_rom_arbiter #(
    .rom_cycle_len (rom_cycle_len)
  ) u_arbiter (
    .CLK2         (CLK2),
    .rst          (rst),
    .cycle_start  (cycle_start),
    .cycle_end    (cycle_end),
    .rom_hit      (rom_hit),
    .snes_dead    (snes_dead),
    .snes_alive   (snes_alive),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .state        (state),
    .rom_addr_mcu (rom_addr_mcu),
    .mcu_rdy      (mcu_rdy)
  );

  rom_bus_mux u_bus_mux (
    .CLK2             (CLK2),
    .rst              (rst),
    .state            (state),
    .rom_addr_mcu     (rom_addr_mcu),
    .mapped_addr      (mapped_addr),
    .rom_hit          (rom_hit),
    .snes_read        (snes_read),
    .mcu_dout         (mcu_dout),
    .rom_data         (rom_data),
    .snes_data        (snes_data),
    .rom_addr         (rom_addr),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .mcu_din          (mcu_din),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir)
  );

endmodule

// ==== verilog/snes_rom_pkg.sv ====
package snes_rom_pkg;

  // cartridge memory map
  typedef enum logic [1:0] {
    map_hirom,
    map_lorom
  } mapper_t;

  // microcontroller access FSM
  typedef enum logic [2:0] {
    st_idle,
    st_rd_addr,
    st_rd_end,
    st_wr_addr,
    st_wr_end
  } arb_state_t;

  typedef logic [23:0] snes_addr_t;
  typedef logic [23:0] rom_addr_t;   // bit 0 picks the byte lane

  //////////////////////////////////////////////////////////////////////////////
  // defaults, top level may override
  //////////////////////////////////////////////////////////////////////////////

  localparam logic [3:0]  def_rom_cycle_len = 4'd8;
  localparam logic [17:0] def_dead_timeout  = 18'd96000;   // 1 ms of CLK2

endpackage
